// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= feat_store_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/bank_sram.sv ====
module bank_sram (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_req_valid,
    input  logic                     mem_req_is_wr,
    input  mem_geom_pkg::bank_addr_t mem_req_addr,
    input  mem_geom_pkg::word_t      mem_req_wdata,
    output logic                     mem_req_ready,
    output logic                     mem_rvalid,
    output mem_geom_pkg::word_t      mem_rdata
);
    import mem_geom_pkg::*;

    word_t mem [2**BANK_AW];

    logic wr_last;
    logic fire;

    // bus turnaround, a read right behind a write waits one cycle
    assign mem_req_ready = !(wr_last && !mem_req_is_wr);
    assign fire          = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (fire && mem_req_is_wr) begin
            mem[mem_req_addr] <= mem_req_wdata;
        end
        if (fire && !mem_req_is_wr) begin
            mem_rdata <= mem[mem_req_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_last    <= 1'b0;
            mem_rvalid <= 1'b0;
        end else begin
            wr_last    <= fire && mem_req_is_wr;
            mem_rvalid <= fire && !mem_req_is_wr;
        end
    end

endmodule

// ==== hdl/beat_gather.sv ====
module beat_gather #(
    parameter int NUM_LANES = 4
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [NUM_LANES-1:0]    beat_valid,
    output logic [NUM_LANES-1:0]    beat_ready,
    input  mem_geom_pkg::word_t     beat_data [NUM_LANES],
    input  feat_req_pkg::tag_t      beat_tag  [NUM_LANES],
    input  mem_geom_pkg::beat_idx_t beat_idx  [NUM_LANES],

    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output mem_geom_pkg::feat_t     rsp_data,
    output feat_req_pkg::tag_t      rsp_tag
);
    import mem_geom_pkg::*;
    import feat_req_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    feat_t lane_feat [NUM_LANES];
    tag_t  lane_tag  [NUM_LANES];

    logic [NUM_LANES-1:0] lane_done;
    logic [NUM_LANES-1:0] cand_mask;
    logic [LANE_W-1:0]    rr_ptr;
    logic [LANE_W-1:0]    rsp_lane;
    logic [LANE_W-1:0]    pick_lane;
    logic                 pick_found;
    logic                 rsp_fire;
    logic                 rsp_load;

    // a finished lane holds its feature until the host takes it
    assign beat_ready = ~lane_done;
    assign rsp_fire   = rsp_valid && rsp_ready;
    assign rsp_load   = !rsp_valid || rsp_fire;

    // ================================================
    // per lane reassembly
    // ================================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (beat_valid[i] && beat_ready[i]) begin
                lane_feat[i][beat_idx[i]*BUS_W +: BUS_W] <= beat_data[i];
                lane_tag[i] <= beat_tag[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_done <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (beat_valid[i] && beat_ready[i] &&
                    beat_idx[i] == beat_idx_t'(WORDS_PER_FEAT - 1)) begin
                    lane_done[i] <= 1'b1;
                end else if (rsp_fire && rsp_lane == LANE_W'(i)) begin
                    lane_done[i] <= 1'b0;
                end
            end
        end
    end

    // ================================================
    // round robin response
    // ================================================
    always_comb begin
        cand_mask = lane_done;
        if (rsp_valid) begin
            cand_mask[rsp_lane] = 1'b0;
        end
    end

    always_comb begin
        logic [LANE_W-1:0] cand;
        pick_found = 1'b0;
        pick_lane  = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = rr_ptr + LANE_W'(k);
            if (!pick_found && cand_mask[cand]) begin
                pick_found = 1'b1;
                pick_lane  = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_lane  <= '0;
            rr_ptr    <= '0;
        end else begin
            if (rsp_load) begin
                rsp_valid <= pick_found;
            end
            if (rsp_load && pick_found) begin
                rsp_lane <= pick_lane;
            end
            if (rsp_fire) begin
                rr_ptr <= rsp_lane + 1'b1;
            end
        end
    end

    // the presented lane is done, so its register stays put
    assign rsp_data = lane_feat[rsp_lane];
    assign rsp_tag  = lane_tag[rsp_lane];

endmodule

// ==== hdl/burst_engine.sv ====
module burst_engine #(
    parameter int REQ_DEPTH  = 2,
    parameter int META_DEPTH = 16,
    parameter int BEAT_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_is_wr,
    input  mem_geom_pkg::feat_t      req_wdata,
    input  feat_req_pkg::tag_t       req_tag,
    input  mem_geom_pkg::bank_addr_t req_addr,

    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic                     mem_req_is_wr,
    output mem_geom_pkg::bank_addr_t mem_req_addr,
    output mem_geom_pkg::word_t      mem_req_wdata,

    input  logic                     mem_rvalid,
    input  mem_geom_pkg::word_t      mem_rdata,

    output logic                     beat_valid,
    input  logic                     beat_ready,
    output mem_geom_pkg::word_t      beat_data,
    output feat_req_pkg::tag_t       beat_tag,
    output mem_geom_pkg::beat_idx_t  beat_idx
);
    import mem_geom_pkg::*;
    import feat_req_pkg::*;

    localparam int RQ_PW = $clog2(REQ_DEPTH);
    localparam int MQ_PW = $clog2(META_DEPTH);
    localparam int BQ_PW = $clog2(BEAT_DEPTH);

    // ================================================
    // request queue and current slot
    // ================================================
    logic       rq_is_wr [REQ_DEPTH];
    tag_t       rq_tag   [REQ_DEPTH];
    bank_addr_t rq_addr  [REQ_DEPTH];
    feat_t      rq_data  [REQ_DEPTH];
    logic [RQ_PW-1:0]               rq_wptr;
    logic [RQ_PW-1:0]               rq_rptr;
    logic [$clog2(REQ_DEPTH+1)-1:0] rq_cnt;

    logic       cur_valid;
    logic       cur_is_wr;
    tag_t       cur_tag;
    bank_addr_t cur_addr;
    feat_t      cur_data;
    beat_idx_t  cur_beat;

    logic rq_push;
    logic cur_load;
    logic cmd_fire;
    logic last_fire;
    logic rd_credit;

    assign req_ready = rq_cnt < REQ_DEPTH;
    assign rq_push   = req_valid && req_ready;
    assign cmd_fire  = mem_req_valid && mem_req_ready;
    assign last_fire = cmd_fire && (cur_beat == beat_idx_t'(WORDS_PER_FEAT - 1));
    // next request moves in as the last word goes out
    assign cur_load  = (!cur_valid || last_fire) && (rq_cnt != 0);

    always_ff @(posedge clk) begin
        if (rq_push) begin
            rq_is_wr[rq_wptr] <= req_is_wr;
            rq_tag[rq_wptr]   <= req_tag;
            rq_addr[rq_wptr]  <= req_addr;
            rq_data[rq_wptr]  <= req_wdata;
        end
        if (cur_load) begin
            cur_is_wr <= rq_is_wr[rq_rptr];
            cur_tag   <= rq_tag[rq_rptr];
            cur_addr  <= rq_addr[rq_rptr];
            cur_data  <= rq_data[rq_rptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rq_wptr   <= '0;
            rq_rptr   <= '0;
            rq_cnt    <= '0;
            cur_valid <= 1'b0;
            cur_beat  <= '0;
        end else begin
            if (rq_push) begin
                rq_wptr <= (rq_wptr == RQ_PW'(REQ_DEPTH - 1)) ? '0 : rq_wptr + 1'b1;
            end
            if (cur_load) begin
                rq_rptr   <= (rq_rptr == RQ_PW'(REQ_DEPTH - 1)) ? '0 : rq_rptr + 1'b1;
                cur_valid <= 1'b1;
                cur_beat  <= '0;
            end else if (cmd_fire) begin
                // last word retires the slot
                if (last_fire) begin
                    cur_valid <= 1'b0;
                end
                cur_beat <= cur_beat + 1'b1;
            end
            if (rq_push && !cur_load) begin
                rq_cnt <= rq_cnt + 1'b1;
            end else if (!rq_push && cur_load) begin
                rq_cnt <= rq_cnt - 1'b1;
            end
        end
    end

    // ================================================
    // word commands
    // ================================================
    assign mem_req_valid = cur_valid && (cur_is_wr || rd_credit);
    assign mem_req_is_wr = cur_is_wr;
    assign mem_req_addr  = cur_addr + bank_addr_t'(cur_beat);
    assign mem_req_wdata = cur_data[cur_beat*BUS_W +: BUS_W];

    // ================================================
    // read metadata and beat queue
    // ================================================
    tag_t      mq_tag [META_DEPTH];
    beat_idx_t mq_idx [META_DEPTH];
    logic [MQ_PW-1:0]                mq_wptr;
    logic [MQ_PW-1:0]                mq_rptr;
    logic [$clog2(META_DEPTH+1)-1:0] mq_cnt;

    word_t     bq_data [BEAT_DEPTH];
    tag_t      bq_tag  [BEAT_DEPTH];
    beat_idx_t bq_idx  [BEAT_DEPTH];
    logic [BQ_PW-1:0]                bq_wptr;
    logic [BQ_PW-1:0]                bq_rptr;
    logic [$clog2(BEAT_DEPTH+1)-1:0] bq_cnt;

    logic mq_push;
    logic bq_pop;

    // every read in flight or queued needs a beat slot, so a return never stalls
    assign rd_credit = (mq_cnt != META_DEPTH) && (int'(mq_cnt) + int'(bq_cnt) < BEAT_DEPTH);
    assign mq_push   = cmd_fire && !cur_is_wr;
    assign bq_pop    = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (mq_push) begin
            mq_tag[mq_wptr] <= cur_tag;
            mq_idx[mq_wptr] <= cur_beat;
        end
        // returning word meets its metadata here
        if (mem_rvalid) begin
            bq_data[bq_wptr] <= mem_rdata;
            bq_tag[bq_wptr]  <= mq_tag[mq_rptr];
            bq_idx[bq_wptr]  <= mq_idx[mq_rptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mq_wptr <= '0;
            mq_rptr <= '0;
            mq_cnt  <= '0;
            bq_wptr <= '0;
            bq_rptr <= '0;
            bq_cnt  <= '0;
        end else begin
            if (mq_push) begin
                mq_wptr <= (mq_wptr == MQ_PW'(META_DEPTH - 1)) ? '0 : mq_wptr + 1'b1;
            end
            if (mem_rvalid) begin
                mq_rptr <= (mq_rptr == MQ_PW'(META_DEPTH - 1)) ? '0 : mq_rptr + 1'b1;
                bq_wptr <= (bq_wptr == BQ_PW'(BEAT_DEPTH - 1)) ? '0 : bq_wptr + 1'b1;
            end
            if (bq_pop) begin
                bq_rptr <= (bq_rptr == BQ_PW'(BEAT_DEPTH - 1)) ? '0 : bq_rptr + 1'b1;
            end
            if (mq_push && !mem_rvalid) begin
                mq_cnt <= mq_cnt + 1'b1;
            end else if (!mq_push && mem_rvalid) begin
                mq_cnt <= mq_cnt - 1'b1;
            end
            if (mem_rvalid && !bq_pop) begin
                bq_cnt <= bq_cnt + 1'b1;
            end else if (!mem_rvalid && bq_pop) begin
                bq_cnt <= bq_cnt - 1'b1;
            end
        end
    end

    assign beat_valid = bq_cnt != 0;
    assign beat_data  = bq_data[bq_rptr];
    assign beat_tag   = bq_tag[bq_rptr];
    assign beat_idx   = bq_idx[bq_rptr];

endmodule

// ==== hdl/feat_req_pkg.sv ====
package feat_req_pkg;

    // ================================================
    // host request fields
    // ================================================
    localparam int TAG_W = 16;

    // host tags responses itself, no ordering implied
    typedef logic [TAG_W-1:0] tag_t;

    // feature aligned word address, lane bits above the beat bits
    localparam int HOST_AW = 12;

    typedef logic [HOST_AW-1:0] host_addr_t;

endpackage

// ==== hdl/feat_store_top.sv ====
module feat_store_top #(
    parameter int NUM_LANES  = 4,
    parameter int REQ_DEPTH  = 2,
    parameter int META_DEPTH = 16,
    parameter int BEAT_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_is_wr,
    input  mem_geom_pkg::feat_t      req_wdata,
    input  feat_req_pkg::tag_t       req_tag,
    input  feat_req_pkg::host_addr_t req_addr,

    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output mem_geom_pkg::feat_t      rsp_data,
    output feat_req_pkg::tag_t       rsp_tag
);
    import mem_geom_pkg::*;
    import feat_req_pkg::*;

    // dispatcher to lanes
    logic [NUM_LANES-1:0] lane_req_valid;
    logic [NUM_LANES-1:0] lane_req_ready;
    logic                 lane_req_is_wr;
    feat_t                lane_req_wdata;
    tag_t                 lane_req_tag;
    bank_addr_t           lane_req_addr;

    // lanes to gatherer
    logic [NUM_LANES-1:0] beat_valid;
    logic [NUM_LANES-1:0] beat_ready;
    word_t                beat_data [NUM_LANES];
    tag_t                 beat_tag  [NUM_LANES];
    beat_idx_t            beat_idx  [NUM_LANES];

    req_dispatch #(
        .NUM_LANES(NUM_LANES)
    ) u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_is_wr     (req_is_wr),
        .req_wdata     (req_wdata),
        .req_tag       (req_tag),
        .req_addr      (req_addr),
        .lane_req_valid(lane_req_valid),
        .lane_req_ready(lane_req_ready),
        .lane_req_is_wr(lane_req_is_wr),
        .lane_req_wdata(lane_req_wdata),
        .lane_req_tag  (lane_req_tag),
        .lane_req_addr (lane_req_addr)
    );

    // ================================================
    // lanes, one engine and one bank each
    // ================================================
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic       mem_req_valid;
        logic       mem_req_ready;
        logic       mem_req_is_wr;
        bank_addr_t mem_req_addr;
        word_t      mem_req_wdata;
        logic       mem_rvalid;
        word_t      mem_rdata;

        burst_engine #(
            .REQ_DEPTH (REQ_DEPTH),
            .META_DEPTH(META_DEPTH),
            .BEAT_DEPTH(BEAT_DEPTH)
        ) u_engine (
            .clk          (clk),
            .rst          (rst),
            .req_valid    (lane_req_valid[i]),
            .req_ready    (lane_req_ready[i]),
            .req_is_wr    (lane_req_is_wr),
            .req_wdata    (lane_req_wdata),
            .req_tag      (lane_req_tag),
            .req_addr     (lane_req_addr),
            .mem_req_valid(mem_req_valid),
            .mem_req_ready(mem_req_ready),
            .mem_req_is_wr(mem_req_is_wr),
            .mem_req_addr (mem_req_addr),
            .mem_req_wdata(mem_req_wdata),
            .mem_rvalid   (mem_rvalid),
            .mem_rdata    (mem_rdata),
            .beat_valid   (beat_valid[i]),
            .beat_ready   (beat_ready[i]),
            .beat_data    (beat_data[i]),
            .beat_tag     (beat_tag[i]),
            .beat_idx     (beat_idx[i])
        );

        bank_sram u_bank (
            .clk          (clk),
            .rst          (rst),
            .mem_req_valid(mem_req_valid),
            .mem_req_is_wr(mem_req_is_wr),
            .mem_req_addr (mem_req_addr),
            .mem_req_wdata(mem_req_wdata),
            .mem_req_ready(mem_req_ready),
            .mem_rvalid   (mem_rvalid),
            .mem_rdata    (mem_rdata)
        );
    end

    beat_gather #(
        .NUM_LANES(NUM_LANES)
    ) u_gather (
        .clk       (clk),
        .rst       (rst),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready),
        .beat_data (beat_data),
        .beat_tag  (beat_tag),
        .beat_idx  (beat_idx),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag)
    );

endmodule

// ==== hdl/mem_geom_pkg.sv ====
package mem_geom_pkg;

    // ================================================
    // bank word and feature geometry
    // ================================================
    localparam int BUS_W          = 32;
    localparam int WORDS_PER_FEAT = 8;
    localparam int FEAT_W         = BUS_W * WORDS_PER_FEAT;
    localparam int BEAT_IDX_W     = 3;

    // word address inside one bank
    localparam int BANK_AW = 10;

    typedef logic [BUS_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [FEAT_W-1:0] feat_t;

    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
    typedef logic [BANK_AW-1:0]    bank_addr_t;

endpackage

// ==== hdl/req_dispatch.sv ====
module req_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_is_wr,
    input  mem_geom_pkg::feat_t      req_wdata,
    input  feat_req_pkg::tag_t       req_tag,
    input  feat_req_pkg::host_addr_t req_addr,

    output logic [NUM_LANES-1:0]     lane_req_valid,
    input  logic [NUM_LANES-1:0]     lane_req_ready,
    output logic                     lane_req_is_wr,
    output mem_geom_pkg::feat_t      lane_req_wdata,
    output feat_req_pkg::tag_t       lane_req_tag,
    output mem_geom_pkg::bank_addr_t lane_req_addr
);
    import mem_geom_pkg::*;
    import feat_req_pkg::*;

    localparam int LANE_W = $clog2(NUM_LANES);

    logic              hold_valid;
    logic [LANE_W-1:0] hold_lane;
    logic              hold_taken;
    logic              req_fire;

    assign hold_taken = hold_valid && lane_req_ready[hold_lane];
    assign req_ready  = !hold_valid || hold_taken;
    assign req_fire   = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (req_fire) begin
            hold_valid <= 1'b1;
        end else if (hold_taken) begin
            hold_valid <= 1'b0;
        end
    end

    // lane bits sit above the beat bits, the rest folds down into the bank
    always_ff @(posedge clk) begin
        if (req_fire) begin
            hold_lane      <= req_addr[BEAT_IDX_W +: LANE_W];
            lane_req_addr  <= bank_addr_t'((req_addr >> (BEAT_IDX_W + LANE_W)) << BEAT_IDX_W);
            lane_req_is_wr <= req_is_wr;
            lane_req_wdata <= req_wdata;
            lane_req_tag   <= req_tag;
        end
    end

    always_comb begin
        lane_req_valid = '0;
        lane_req_valid[hold_lane] = hold_valid;
    end

endmodule

// ==== sim.f ====
hdl/mem_geom_pkg.sv
hdl/feat_req_pkg.sv
hdl/burst_engine.sv
hdl/bank_sram.sv
hdl/req_dispatch.sv
hdl/beat_gather.sv
hdl/feat_store_top.sv
test/feat_store_checker.sv
test/feat_store_tb.sv

// ==== test/feat_store_checker.sv ====
module feat_store_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     req_valid,
    input logic                     req_ready,
    input logic                     req_is_wr,
    input mem_geom_pkg::feat_t      req_wdata,
    input feat_req_pkg::tag_t       req_tag,
    input feat_req_pkg::host_addr_t req_addr,
    input logic                     rsp_valid,
    input logic                     rsp_ready,
    input mem_geom_pkg::feat_t      rsp_data,
    input feat_req_pkg::tag_t       rsp_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    // ================================================
    // host request side
    // ================================================
    property req_held;
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_is_wr) && $stable(req_addr) &&
                                    $stable(req_tag) && $stable(req_wdata);
    endproperty

    a_req_held: assert property (req_held)
        else $error("request changed while stalled by req_ready");

    // ================================================
    // response side
    // ================================================
    property rsp_held;
        @(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_tag);
    endproperty

    property rsp_quiet_in_reset;
        @(posedge clk)
        rst && $past(rst) |-> !rsp_valid;
    endproperty

    a_rsp_held: assert property (rsp_held)
        else $error("response dropped or changed while rsp_ready was low");

    a_rsp_quiet: assert property (rsp_quiet_in_reset)
        else $error("rsp_valid high during reset");

endmodule

bind feat_store_top feat_store_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_is_wr(req_is_wr),
    .req_wdata(req_wdata),
    .req_tag  (req_tag),
    .req_addr (req_addr),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_data (rsp_data),
    .rsp_tag  (rsp_tag)
);

// ==== test/feat_store_tb.sv ====
module feat_store_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_geom_pkg::*;
    import feat_req_pkg::*;

    localparam int NUM_FEATS      = (2 ** HOST_AW) / WORDS_PER_FEAT;
    localparam int POOL           = 64;
    localparam int RAND_REQS      = 200;
    localparam int STALL_REQS     = 64;
    localparam int STALL_WAIT     = 50;
    localparam int TIMEOUT_CYCLES = RAND_REQS * 40 + 1000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    logic       req_is_wr;
    feat_t      req_wdata;
    tag_t       req_tag;
    host_addr_t req_addr;
    logic       rsp_valid;
    logic       rsp_ready;
    feat_t      rsp_data;
    tag_t       rsp_tag;

    // model memory by feature index, and reads still owed a response
    feat_t      model_mem     [NUM_FEATS];
    bit         model_written [NUM_FEATS];
    int         pend_per_feat [NUM_FEATS];
    host_addr_t pend_addr     [tag_t];

    tag_t next_tag = '0;
    int   rsp_mode = 0;
    int   err_cnt = 0;
    int   test_cnt = 0;
    int   test_fail_cnt = 0;
    int   rsp_cnt = 0;
    int   cycle_cnt = 0;

    feat_store_top uut (
        .clk      (clk),
        .rst      (rst),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_is_wr(req_is_wr),
        .req_wdata(req_wdata),
        .req_tag  (req_tag),
        .req_addr (req_addr),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_data (rsp_data),
        .rsp_tag  (rsp_tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 0 always ready, 1 random, 2 held low
    initial begin
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            case (rsp_mode)
                0: rsp_ready = 1'b1;
                1: rsp_ready = ($urandom % 2) == 0;
                default: rsp_ready = 1'b0;
            endcase
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d reads still unanswered",
                 cycle_cnt, pend_addr.num());
        $display("Test failed");
        $finish;
    end

    // ================================================
    // reference model and checks
    // ================================================
    function automatic int feat_index(input host_addr_t addr);
        return int'(addr >> BEAT_IDX_W);
    endfunction

    function automatic host_addr_t feat_addr(input int f);
        return host_addr_t'(f << BEAT_IDX_W);
    endfunction

    function automatic feat_t expected_feat(input tag_t tag);
        return model_mem[feat_index(pend_addr[tag])];
    endfunction

    function automatic feat_t make_feat();
        feat_t v;
        for (int w = 0; w < WORDS_PER_FEAT; w++) begin
            v[w*BUS_W +: BUS_W] = $urandom;
        end
        return v;
    endfunction

    function automatic int pick_written();
        int f;
        f = $urandom_range(0, POOL - 1);
        while (!model_written[f]) begin
            f = $urandom_range(0, POOL - 1);
        end
        return f;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_feat(input string name, input feat_t got, input feat_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(input tag_t got);
        if (!pend_addr.exists(got)) begin
            $display("ERROR rsp_tag 0x%h is not an outstanding read", got);
            err_cnt++;
        end else begin
            pend_per_feat[feat_index(pend_addr[got])]--;
            pend_addr.delete(got);
        end
    endtask

    // a transfer seen here completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            rsp_cnt++;
            if (pend_addr.exists(rsp_tag)) begin
                check_feat("rsp_data", rsp_data, expected_feat(rsp_tag));
            end
            check_tag(rsp_tag);
        end
    end

    // ================================================
    // stimulus
    // ================================================
    task automatic start_req(input logic is_wr, input host_addr_t addr, input feat_t data);
        int f;
        f = feat_index(addr);
        req_valid = 1'b1;
        req_is_wr = is_wr;
        req_addr  = addr;
        req_wdata = data;
        req_tag   = next_tag;
        if (is_wr) begin
            model_mem[f]     = data;
            model_written[f] = 1'b1;
        end else begin
            pend_addr[next_tag] = addr;
            pend_per_feat[f]++;
        end
        next_tag++;
    endtask

    task automatic wait_accept(input int max_cycles, output bit fired);
        int waited;
        waited = 0;
        fired  = 1'b0;
        while (!fired && waited < max_cycles) begin
            @(negedge clk);
            fired = req_ready;
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic send_req(input logic is_wr, input host_addr_t addr, input feat_t data);
        bit fired;
        start_req(is_wr, addr, data);
        wait_accept(TIMEOUT_CYCLES, fired);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pend_addr.num() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%-28s PASS", name);
        end else begin
            test_fail_cnt++;
            $display("%-28s FAIL, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ================================================
    // tests
    // ================================================
    task automatic run_idle();
        @(negedge clk);
        check_bit("req_ready", req_ready, 1'b1);
        repeat (20) begin
            @(negedge clk);
            check_bit("rsp_valid", rsp_valid, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_write_read();
        // read right behind the write hits the turnaround stall
        send_req(1'b1, feat_addr(101), make_feat());
        send_req(1'b0, feat_addr(101), '0);
        wait_drain();
    endtask

    task automatic run_all_lanes();
        for (int lane = 0; lane < 4; lane++) begin
            send_req(1'b1, feat_addr(((lane * 3 + 5) << 2) | lane), make_feat());
        end
        for (int lane = 0; lane < 4; lane++) begin
            send_req(1'b0, feat_addr(((lane * 3 + 5) << 2) | lane), '0);
        end
        wait_drain();
    endtask

    task automatic run_random();
        int   f;
        logic is_wr;
        rsp_mode = 1;
        for (int i = 0; i < RAND_REQS; i++) begin
            f     = $urandom_range(0, POOL - 1);
            is_wr = $urandom_range(0, 1) == 1;
            // no reads of empty slots, no writes under a pending read
            if (!is_wr && !model_written[f]) begin
                is_wr = 1'b1;
            end else if (is_wr && pend_per_feat[f] != 0) begin
                is_wr = 1'b0;
            end
            send_req(is_wr, feat_addr(f), make_feat());
        end
        wait_drain();
        rsp_mode = 0;
    endtask

    task automatic run_backpressure();
        int n;
        bit fired;
        bit stalled;
        n        = 0;
        stalled  = 1'b0;
        rsp_mode = 2;
        while (!stalled && n < STALL_REQS) begin
            start_req(1'b0, feat_addr(pick_written()), '0);
            wait_accept(STALL_WAIT, fired);
            if (fired) begin
                req_valid = 1'b0;
                n++;
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled) begin
            $display("req_ready never fell with responses held off for %0d reads", n);
            err_cnt++;
        end else begin
            repeat (10) begin
                @(negedge clk);
                check_bit("req_ready", req_ready, 1'b0);
            end
            @(posedge clk);
            #1;
            rsp_mode = 0;
            wait_accept(TIMEOUT_CYCLES, fired);
            req_valid = 1'b0;
        end
        rsp_mode = 0;
        wait_drain();
    endtask

    initial begin
        int e;
        void'($urandom(32'hd1c9));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_is_wr = 1'b0;
        req_wdata = '0;
        req_tag   = '0;
        req_addr  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        e = err_cnt;
        run_idle();
        report_test("reset and idle", e);
        e = err_cnt;
        run_write_read();
        report_test("write then read", e);
        e = err_cnt;
        run_all_lanes();
        report_test("all four lanes", e);
        e = err_cnt;
        run_random();
        report_test("random mixed traffic", e);
        e = err_cnt;
        run_backpressure();
        report_test("response back-pressure", e);

        repeat (20) @(posedge clk);
        $display("tests %0d, failing %0d, errors %0d, responses %0d, cycles %0d",
                 test_cnt, test_fail_cnt, err_cnt, rsp_cnt, cycle_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
